// ==== hw/acc_pkg.sv ====
// accelerator shared types
`default_nettype none

package acc_pkg;

  // lane geometry
  localparam int LANES  = 4;
  localparam int LANE_W = 16;
  localparam int ACC_W  = 32;
  localparam int DATA_W = LANES * LANE_W;

  // one input word, lane 0 in the low bits
  typedef struct packed {
    logic [LANES-1:0][LANE_W-1:0] lane;
  } lane_vec_t;

  // matched ifm and wgt words
  typedef struct packed {
    lane_vec_t ifm;
    lane_vec_t wgt;
  } op_pair_t;

  // one output word of accumulators
  typedef struct packed {
    logic [LANES-1:0][ACC_W-1:0] acc;
  } acc_vec_t;

  // job configuration sampled on start
  typedef struct packed {
    logic [15:0] ci;
    logic [15:0] co;
  } job_cfg_t;

  typedef enum logic {
    C_IDLE,
    C_RUN
  } ctrl_state_e;

  typedef enum logic {
    F_IDLE,
    F_FETCH
  } fetch_state_e;

  typedef enum logic {
    M_ACCUM,
    M_EMIT
  } mac_state_e;

endpackage

`default_nettype wire

// ==== hw/acc_ctrl.sv ====
// job start and status control
`default_nettype none
`timescale 1ns/1ns

module acc_ctrl (
  input  logic              ap_clk,
  input  logic              ap_rst_n,
  input  logic              ap_start,
  input  acc_pkg::job_cfg_t cfg,
  input  logic              job_end,
  output acc_pkg::job_cfg_t job_cfg,
  output logic              run,
  output logic              ap_idle,
  output logic              ap_done
);

  acc_pkg::ctrl_state_e state;
  acc_pkg::job_cfg_t    cfg_q;
  logic                 done_q;

  // a start only counts while idle
  logic start_acc;
  assign start_acc = ap_start && (state == acc_pkg::C_IDLE);

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      state  <= acc_pkg::C_IDLE;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        acc_pkg::C_IDLE: begin
          if (start_acc) begin
            state <= acc_pkg::C_RUN;
          end
        end
        acc_pkg::C_RUN: begin
          if (job_end) begin
            state  <= acc_pkg::C_IDLE;
            done_q <= 1'b1;
          end
        end
        default: state <= acc_pkg::C_IDLE;
      endcase
    end
  end

  // config held for the whole job
  always_ff @(posedge ap_clk) begin
    if (start_acc) begin
      cfg_q <= cfg;
    end
  end

  assign job_cfg = cfg_q;
  assign run     = (state == acc_pkg::C_RUN);
  assign ap_idle = (state == acc_pkg::C_IDLE);
  assign ap_done = done_q;

endmodule

`default_nettype wire

// ==== hw/operand_fetch.sv ====
// operand pair producer
`default_nettype none
`timescale 1ns/1ns

module operand_fetch #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic               ap_clk,
  input  logic               ap_rst_n,
  input  logic               run,
  input  acc_pkg::job_cfg_t  job_cfg,
  input  logic               ifm_valid,
  output logic               ifm_ready,
  input  acc_pkg::lane_vec_t ifm_data,
  input  logic               wgt_valid,
  output logic               wgt_ready,
  input  acc_pkg::lane_vec_t wgt_data,
  input  logic               credit,
  output logic               push,
  output acc_pkg::op_pair_t  push_pair
);

  localparam int CRD_W = $clog2(FIFO_DEPTH + 1);

  acc_pkg::fetch_state_e state;
  logic [CRD_W-1:0]      credits;
  logic [31:0]           pairs_left;
  logic                  run_q;
  logic                  take;

  // memory byte 0 sits in the top byte
  function automatic logic [acc_pkg::DATA_W-1:0] byte_swap(
    input logic [acc_pkg::DATA_W-1:0] w
  );
    logic [acc_pkg::DATA_W-1:0] r;
    for (int b = 0; b < acc_pkg::DATA_W / 8; b++) begin
      r[b*8 +: 8] = w[(acc_pkg::DATA_W/8 - 1 - b)*8 +: 8];
    end
    return r;
  endfunction

  // both words move together or not at all
  assign take = (state == acc_pkg::F_FETCH) && (credits != '0) && ifm_valid && wgt_valid;
  assign ifm_ready = take;
  assign wgt_ready = take;

  assign push          = take;
  assign push_pair.ifm = byte_swap(ifm_data);
  assign push_pair.wgt = byte_swap(wgt_data);

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      state      <= acc_pkg::F_IDLE;
      pairs_left <= '0;
      run_q      <= 1'b0;
    end else begin
      run_q <= run;
      case (state)
        acc_pkg::F_IDLE: begin
          // new job on the rising edge of run
          if (run && !run_q) begin
            pairs_left <= job_cfg.ci * job_cfg.co;
            state      <= acc_pkg::F_FETCH;
          end
        end
        acc_pkg::F_FETCH: begin
          if (take) begin
            pairs_left <= pairs_left - 32'd1;
            if (pairs_left == 32'd1) begin
              state <= acc_pkg::F_IDLE;
            end
          end
        end
        default: state <= acc_pkg::F_IDLE;
      endcase
    end
  end

  // one credit per free fifo slot
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      credits <= CRD_W'(FIFO_DEPTH);
    end else if (take && !credit) begin
      credits <= credits - 1'b1;
    end else if (!take && credit) begin
      credits <= credits + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/operand_fifo.sv ====
// operand pair buffer
`default_nettype none
`timescale 1ns/1ns

module operand_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              ap_clk,
  input  logic              ap_rst_n,
  input  logic              push,
  input  acc_pkg::op_pair_t push_pair,
  output logic              pop_valid,
  output acc_pkg::op_pair_t pop_pair,
  input  logic              pop,
  output logic              credit
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  acc_pkg::op_pair_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              do_pop;
  logic              credit_q;

  assign do_pop = pop && pop_valid;

  // no full check, the producer never overruns its credits
  always_ff @(posedge ap_clk) begin
    if (push) begin
      mem[wr_ptr] <= push_pair;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_q <= 1'b0;
    end else begin
      credit_q <= do_pop;
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !do_pop) begin
        count <= count + 1'b1;
      end else if (!push && do_pop) begin
        count <= count - 1'b1;
      end
    end
  end

  assign pop_valid = (count != '0);
  assign pop_pair  = mem[rd_ptr];
  assign credit    = credit_q;

endmodule

`default_nettype wire

// ==== hw/mac_engine.sv ====
// lane-wise multiply-accumulate engine
`default_nettype none
`timescale 1ns/1ns

module mac_engine (
  input  logic              ap_clk,
  input  logic              ap_rst_n,
  input  logic              run,
  input  acc_pkg::job_cfg_t job_cfg,
  input  logic              pop_valid,
  input  acc_pkg::op_pair_t pop_pair,
  output logic              pop,
  output logic              ofm_valid,
  input  logic              ofm_ready,
  output acc_pkg::acc_vec_t ofm_data,
  output logic              job_end
);

  acc_pkg::mac_state_e                          state;
  logic [acc_pkg::LANES-1:0][acc_pkg::ACC_W-1:0] acc;
  logic [acc_pkg::LANES-1:0][acc_pkg::ACC_W-1:0] acc_sum;
  logic [acc_pkg::LANES-1:0][acc_pkg::ACC_W-1:0] acc_swap;
  logic [15:0]                                  pair_cnt;
  logic [15:0]                                  word_cnt;
  logic                                         last_pair;
  logic                                         last_word;
  logic                                         emit_fire;

  // stall while a result is waiting
  assign pop       = (state == acc_pkg::M_ACCUM) && run && pop_valid;
  assign last_pair = (pair_cnt == job_cfg.ci - 16'd1);
  assign last_word = (word_cnt == job_cfg.co - 16'd1);
  assign emit_fire = (state == acc_pkg::M_EMIT) && ofm_ready;

  // unsigned products, sum wraps at 32 bits
  always_comb begin
    for (int l = 0; l < acc_pkg::LANES; l++) begin
      acc_sum[l] = acc[l] + acc_pkg::ACC_W'(pop_pair.ifm.lane[l]) *
                            acc_pkg::ACC_W'(pop_pair.wgt.lane[l]);
    end
  end

  // each accumulator goes out byte-reversed
  always_comb begin
    for (int l = 0; l < acc_pkg::LANES; l++) begin
      for (int b = 0; b < acc_pkg::ACC_W / 8; b++) begin
        acc_swap[l][b*8 +: 8] = acc[l][(acc_pkg::ACC_W/8 - 1 - b)*8 +: 8];
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      state    <= acc_pkg::M_ACCUM;
      acc      <= '0;
      pair_cnt <= '0;
      word_cnt <= '0;
    end else begin
      case (state)
        acc_pkg::M_ACCUM: begin
          if (pop) begin
            acc <= acc_sum;
            if (last_pair) begin
              pair_cnt <= '0;
              state    <= acc_pkg::M_EMIT;
            end else begin
              pair_cnt <= pair_cnt + 16'd1;
            end
          end
        end
        acc_pkg::M_EMIT: begin
          if (emit_fire) begin
            acc      <= '0;
            state    <= acc_pkg::M_ACCUM;
            word_cnt <= last_word ? '0 : word_cnt + 16'd1;
          end
        end
        default: state <= acc_pkg::M_ACCUM;
      endcase
    end
  end

  assign ofm_valid    = (state == acc_pkg::M_EMIT);
  assign ofm_data.acc = acc_swap;

  // last accepted word of the job
  assign job_end = emit_fire && last_word;

endmodule

`default_nettype wire

// ==== hw/krnl_acc.sv ====
// accelerator kernel top level
`default_nettype none
`timescale 1ns/1ns

module krnl_acc #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic               ap_clk,
  input  logic               ap_rst_n,
  input  logic               ap_start,
  input  acc_pkg::job_cfg_t  cfg,
  output logic               ap_idle,
  output logic               ap_done,
  input  logic               ifm_valid,
  output logic               ifm_ready,
  input  acc_pkg::lane_vec_t ifm_data,
  input  logic               wgt_valid,
  output logic               wgt_ready,
  input  acc_pkg::lane_vec_t wgt_data,
  output logic               ofm_valid,
  input  logic               ofm_ready,
  output acc_pkg::acc_vec_t  ofm_data
);

  acc_pkg::job_cfg_t job_cfg;
  logic              run;
  logic              job_end;

  // producer to buffer
  logic              push;
  acc_pkg::op_pair_t push_pair;
  logic              credit;

  // buffer to consumer
  logic              pop_valid;
  acc_pkg::op_pair_t pop_pair;
  logic              pop;

  acc_ctrl i_acc_ctrl (
    .ap_clk   (ap_clk),
    .ap_rst_n (ap_rst_n),
    .ap_start (ap_start),
    .cfg      (cfg),
    .job_end  (job_end),
    .job_cfg  (job_cfg),
    .run      (run),
    .ap_idle  (ap_idle),
    .ap_done  (ap_done)
  );

  operand_fetch #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_operand_fetch (
    .ap_clk    (ap_clk),
    .ap_rst_n  (ap_rst_n),
    .run       (run),
    .job_cfg   (job_cfg),
    .ifm_valid (ifm_valid),
    .ifm_ready (ifm_ready),
    .ifm_data  (ifm_data),
    .wgt_valid (wgt_valid),
    .wgt_ready (wgt_ready),
    .wgt_data  (wgt_data),
    .credit    (credit),
    .push      (push),
    .push_pair (push_pair)
  );

  operand_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_operand_fifo (
    .ap_clk    (ap_clk),
    .ap_rst_n  (ap_rst_n),
    .push      (push),
    .push_pair (push_pair),
    .pop_valid (pop_valid),
    .pop_pair  (pop_pair),
    .pop       (pop),
    .credit    (credit)
  );

  mac_engine i_mac_engine (
    .ap_clk    (ap_clk),
    .ap_rst_n  (ap_rst_n),
    .run       (run),
    .job_cfg   (job_cfg),
    .pop_valid (pop_valid),
    .pop_pair  (pop_pair),
    .pop       (pop),
    .ofm_valid (ofm_valid),
    .ofm_ready (ofm_ready),
    .ofm_data  (ofm_data),
    .job_end   (job_end)
  );

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
// testbench clock and reset
`default_nettype none
`timescale 1ns/1ns

module tb_clk_gen (
  input  logic rst_req,
  output logic ap_clk,
  output logic ap_rst_n
);

  logic por_done;

  // 20 ns period
  initial begin
    ap_clk = 1'b0;
    forever #10 ap_clk = ~ap_clk;
  end

  // power-on reset over the first 5 cycles
  initial begin
    por_done = 1'b0;
    repeat (5) @(posedge ap_clk);
    #2;
    por_done = 1'b1;
  end

  // rst_req lets the testbench reset in the middle of a job
  assign ap_rst_n = por_done && !rst_req;

endmodule

`default_nettype wire

// ==== dv/krnl_acc_properties.sv ====
// kernel handshake assertions
`default_nettype none
`timescale 1ns/1ns

module krnl_acc_properties (
  input logic              ap_clk,
  input logic              ap_rst_n,
  input logic              ap_done,
  input logic              ifm_valid,
  input logic              ifm_ready,
  input logic              wgt_valid,
  input logic              wgt_ready,
  input logic              ofm_valid,
  input logic              ofm_ready,
  input acc_pkg::acc_vec_t ofm_data
);

  int assert_errs = 0;

  // a waiting result keeps its value
  ofm_hold: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    ofm_valid && !ofm_ready |=> ofm_valid && $stable(ofm_data))
  else begin
    assert_errs++;
    $error("ofm_data or ofm_valid changed while ofm_ready was low");
  end

  done_pulse: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    ap_done |=> !ap_done)
  else begin
    assert_errs++;
    $error("ap_done stayed high for two cycles");
  end

  // both streams move together and only when both are valid
  ready_pair: assert property (@(posedge ap_clk)
    ifm_ready == wgt_ready && (!ifm_ready || (ifm_valid && wgt_valid)))
  else begin
    assert_errs++;
    $error("ifm_ready and wgt_ready differ or rose without both valids");
  end

endmodule

`default_nettype wire

// ==== dv/tb_krnl_acc.sv ====
// kernel testbench
`default_nettype none
`timescale 1ns/1ns

module tb_krnl_acc;

  localparam int NJOBS = 16;

  logic               ap_clk;
  logic               ap_rst_n;
  logic               rst_req;
  logic               ap_start;
  acc_pkg::job_cfg_t  cfg;
  logic               ap_idle;
  logic               ap_done;
  logic               ifm_valid;
  logic               ifm_ready;
  acc_pkg::lane_vec_t ifm_data;
  logic               wgt_valid;
  logic               wgt_ready;
  acc_pkg::lane_vec_t wgt_data;
  logic               ofm_valid;
  logic               ofm_ready;
  acc_pkg::acc_vec_t  ofm_data;

  integer       seed = 32'h06c1_61e4;
  int           cycles = 0;
  int           limit = 0;
  int           n_checks = 0;
  int           n_errors = 0;
  logic         abort;
  logic         job_over;
  logic [63:0]  ifm_words[$];
  logic [63:0]  wgt_words[$];
  logic [127:0] exp_q[$];
  int           job_ci[NJOBS];
  int           job_co[NJOBS];

  tb_clk_gen i_tb_clk_gen (
    .rst_req  (rst_req),
    .ap_clk   (ap_clk),
    .ap_rst_n (ap_rst_n)
  );

  krnl_acc #(
    .FIFO_DEPTH (4)
  ) i_krnl_acc (
    .ap_clk    (ap_clk),
    .ap_rst_n  (ap_rst_n),
    .ap_start  (ap_start),
    .cfg       (cfg),
    .ap_idle   (ap_idle),
    .ap_done   (ap_done),
    .ifm_valid (ifm_valid),
    .ifm_ready (ifm_ready),
    .ifm_data  (ifm_data),
    .wgt_valid (wgt_valid),
    .wgt_ready (wgt_ready),
    .wgt_data  (wgt_data),
    .ofm_valid (ofm_valid),
    .ofm_ready (ofm_ready),
    .ofm_data  (ofm_data)
  );

  bind krnl_acc krnl_acc_properties i_krnl_acc_properties (
    .ap_clk    (ap_clk),
    .ap_rst_n  (ap_rst_n),
    .ap_done   (ap_done),
    .ifm_valid (ifm_valid),
    .ifm_ready (ifm_ready),
    .wgt_valid (wgt_valid),
    .wgt_ready (wgt_ready),
    .ofm_valid (ofm_valid),
    .ofm_ready (ofm_ready),
    .ofm_data  (ofm_data)
  );

  function automatic logic [31:0] swap32(input logic [31:0] a);
    return {a[7:0], a[15:8], a[23:16], a[31:24]};
  endfunction

  // memory byte 0 ends up in bits 63:56
  function automatic logic [63:0] swap64(input logic [63:0] w);
    return {swap32(w[31:0]), swap32(w[63:32])};
  endfunction

  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // reference model builds one expected word per ci pairs
  task automatic build_random_job(input int ci, input int co);
    logic [63:0]  a;
    logic [63:0]  b;
    logic [31:0]  acc [4];
    logic [127:0] word;
    for (int k = 0; k < co; k++) begin
      for (int l = 0; l < 4; l++) begin
        acc[l] = '0;
      end
      for (int p = 0; p < ci; p++) begin
        a = {$random(seed), $random(seed)};
        b = {$random(seed), $random(seed)};
        ifm_words.push_back(swap64(a));
        wgt_words.push_back(swap64(b));
        for (int l = 0; l < 4; l++) begin
          acc[l] = acc[l] + {16'h0, a[l*16 +: 16]} * {16'h0, b[l*16 +: 16]};
        end
      end
      for (int l = 0; l < 4; l++) begin
        word[l*32 +: 32] = swap32(acc[l]);
      end
      exp_q.push_back(word);
    end
  endtask

  // random valids while each word stays until it moves
  task automatic drive_inputs();
    logic fire;
    while (ifm_words.size() > 0 && !abort) begin
      ifm_valid = ($random(seed) & 3) != 0;
      wgt_valid = ($random(seed) & 3) != 0;
      ifm_data  = ifm_words[0];
      wgt_data  = wgt_words[0];
      @(negedge ap_clk);
      fire = ifm_valid && ifm_ready;
      @(posedge ap_clk);
      #2;
      if (fire) begin
        ifm_words.delete(0);
        wgt_words.delete(0);
      end
    end
    ifm_valid = 1'b0;
    wgt_valid = 1'b0;
  endtask

  task automatic drive_ofm_ready(input int pct);
    while (!job_over) begin
      ofm_ready = ($unsigned($random(seed)) % 100) < pct;
      @(posedge ap_clk);
      #2;
    end
    ofm_ready = 1'b1;
  endtask

  task automatic watch_outputs(input string name, input int co);
    int           words;
    int           last_cyc;
    logic         seen_done;
    logic [127:0] want;
    words     = 0;
    last_cyc  = -10;
    seen_done = 1'b0;
    while (!seen_done && !abort) begin
      @(negedge ap_clk);
      if (ap_done) begin
        seen_done = 1'b1;
        check_value({name, " word count"}, co, words);
        check_value({name, " done one cycle after last word"}, last_cyc + 1, cycles);
        check_value({name, " idle with done"}, 1, ap_idle);
      end
      if (ofm_valid && ofm_ready) begin
        if (exp_q.size() == 0) begin
          n_errors++;
          $display("[ERROR] %s: ofm word arrived with no word left to expect", name);
        end else begin
          want = exp_q.pop_front();
          check_value({name, " ofm word"}, want, ofm_data);
        end
        words++;
        last_cyc = cycles;
      end
    end
    job_over = 1'b1;
  endtask

  // entered and left 2 ns after a rising edge
  task automatic run_job(input string name, input int ci, input int co, input int pct,
                         input bit poke, input int abort_at);
    abort    = 1'b0;
    job_over = 1'b0;
    cfg.ci   = 16'(ci);
    cfg.co   = 16'(co);
    ap_start = 1'b1;
    fork
      begin
        @(posedge ap_clk);
        #2;
        // a second start while busy must be ignored
        if (poke) begin
          cfg.ci = 16'(ci + 1);
          cfg.co = 16'(co + 2);
          @(posedge ap_clk);
          #2;
        end
        ap_start = 1'b0;
      end
      drive_inputs();
      drive_ofm_ready(pct);
      watch_outputs(name, co);
      begin
        if (abort_at > 0) begin
          repeat (abort_at) @(posedge ap_clk);
          #2;
          rst_req = 1'b1;
          abort   = 1'b1;
          repeat (3) @(posedge ap_clk);
          #2;
          rst_req = 1'b0;
        end
      end
    join
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (n_errors == errs_before)
      $display("%s: ok", name);
    else
      $display("%s: %0d errors", name, n_errors - errs_before);
  endtask

  // run limit
  always @(posedge ap_clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    int total;
    int e0;
    rst_req   = 1'b0;
    ap_start  = 1'b0;
    cfg       = '0;
    ifm_valid = 1'b0;
    ifm_data  = '0;
    wgt_valid = 1'b0;
    wgt_data  = '0;
    ofm_ready = 1'b1;
    abort     = 1'b0;
    job_over  = 1'b0;
    total     = 0;
    job_ci[0] = 1;
    job_co[0] = 1;
    for (int j = 1; j < NJOBS; j++) begin
      job_ci[j] = 1 + ($unsigned($random(seed)) % 8);
      job_co[j] = 1 + ($unsigned($random(seed)) % 6);
    end
    // long enough to be cut by the reset
    job_ci[14] = 6;
    job_co[14] = 4;
    for (int j = 0; j < NJOBS; j++) begin
      total += job_ci[j] * job_co[j];
    end
    limit = 8 * total + 200 * 5;
    wait (ap_rst_n === 1'b1);
    @(posedge ap_clk);
    #2;

    // lanes 1..4 times 5..8 with a hand-computed result
    e0 = n_errors;
    ifm_words.push_back(64'h0100_0200_0300_0400);
    wgt_words.push_back(64'h0500_0600_0700_0800);
    exp_q.push_back(128'h2000_0000_1500_0000_0c00_0000_0500_0000);
    run_job("test 1 byte order", 1, 1, 100, 1'b0, 0);
    report_test("test 1 byte order", e0);

    e0 = n_errors;
    for (int j = 1; j <= 6; j++) begin
      build_random_job(job_ci[j], job_co[j]);
      run_job("test 2 random jobs", job_ci[j], job_co[j], 100, 1'b0, 0);
    end
    report_test("test 2 random jobs", e0);

    e0 = n_errors;
    for (int j = 7; j <= 10; j++) begin
      build_random_job(job_ci[j], job_co[j]);
      run_job("test 3 ofm back-pressure", job_ci[j], job_co[j], 50, 1'b0, 0);
    end
    report_test("test 3 ofm back-pressure", e0);

    e0 = n_errors;
    for (int j = 11; j <= 13; j++) begin
      build_random_job(job_ci[j], job_co[j]);
      run_job("test 4 back-to-back", job_ci[j], job_co[j], 75, 1'b1, 0);
    end
    report_test("test 4 back-to-back", e0);

    e0 = n_errors;
    build_random_job(job_ci[14], job_co[14]);
    run_job("test 5 reset mid-job", job_ci[14], job_co[14], 100, 1'b0, 12);
    ifm_words.delete();
    wgt_words.delete();
    exp_q.delete();
    // valids high so the readys have a reason to rise
    ifm_valid = 1'b1;
    wgt_valid = 1'b1;
    @(negedge ap_clk);
    check_value("test 5 idle after reset", 1, ap_idle);
    check_value("test 5 ofm_valid after reset", 0, ofm_valid);
    check_value("test 5 ap_done after reset", 0, ap_done);
    check_value("test 5 readys after reset", 0, {ifm_ready, wgt_ready});
    @(posedge ap_clk);
    #2;
    ifm_valid = 1'b0;
    wgt_valid = 1'b0;
    build_random_job(job_ci[15], job_co[15]);
    run_job("test 5 job after reset", job_ci[15], job_co[15], 75, 1'b0, 0);
    report_test("test 5 reset mid-job", e0);

    n_errors += i_krnl_acc.i_krnl_acc_properties.assert_errs;
    $display("tests 5, checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== krnl_acc.f ====
hw/acc_pkg.sv
hw/acc_ctrl.sv
hw/operand_fetch.sv
hw/operand_fifo.sv
hw/mac_engine.sv
hw/krnl_acc.sv
dv/tb_clk_gen.sv
dv/krnl_acc_properties.sv
dv/tb_krnl_acc.sv

// ==== Makefile ====
# Verilator build and run of the kernel testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search sim.log for the pass line"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_krnl_acc \
	  -f krnl_acc.f -Mdir obj_dir -o sim_krnl_acc
	./obj_dir/sim_krnl_acc | tee sim.log
	grep -qx "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
